// File: hw/idctPkg.sv
// sequencer state encoding for the 8x8 IDCT
// block geometry, cosine width and accumulator headroom
package idctPkg;

   // block geometry
   localparam int BlockDim   = 8;
   localparam int IndexWidth = 3;
   localparam int BlockWords = BlockDim * BlockDim;

   // wide enough for the 512 MAC steps of one pass
   localparam int StepWidth = 9;

   // stored width of the cosine constants
   localparam int CosWidth = 16;

   // extra accumulator bits above the data width
   localparam int AccGuard = 3;

   // sequencer states
   typedef enum logic [2:0] {
      Idle,
      // samples arrive while reading is high
      Load,
      RowPass,
      RowFlush,
      ColPass,
      ColFlush,
      // results leave with outValid
      Unload
   } idctState;

endpackage

// File: hw/cosineRom.sv
// cosine constant table for the IDCT passes
// signed 16-bit entries, sign-extended to the operand width
`timescale 1ns/10ps

module cosineRom #(
   parameter int OperandWidth = 24
) (
   input  logic [idctPkg::IndexWidth-1:0] row,
   input  logic [idctPkg::IndexWidth-1:0] col,
   output logic [OperandWidth-1:0]        coef
);
   import idctPkg::*;

   // entry [x][u] is cos((2x+1)u pi/16) scaled by 2^15, dc column carries 1/sqrt2
   localparam logic signed [CosWidth-1:0] CosTable [BlockWords] = '{
      16'sd23170,  16'sd32138,  16'sd30274,  16'sd27246,
      16'sd23170,  16'sd18205,  16'sd12540,  16'sd6393,
      16'sd23170,  16'sd27246,  16'sd12540, -16'sd6393,
      -16'sd23170, -16'sd32138, -16'sd30274, -16'sd18205,
      16'sd23170,  16'sd18205, -16'sd12540, -16'sd32138,
      -16'sd23170, 16'sd6393,   16'sd30274,  16'sd27246,
      16'sd23170,  16'sd6393,  -16'sd30274, -16'sd18205,
      16'sd23170,  16'sd27246, -16'sd12540, -16'sd32138,
      16'sd23170, -16'sd6393,  -16'sd30274,  16'sd18205,
      16'sd23170, -16'sd27246, -16'sd12540,  16'sd32138,
      16'sd23170, -16'sd18205, -16'sd12540,  16'sd32138,
      -16'sd23170, -16'sd6393,  16'sd30274, -16'sd27246,
      16'sd23170, -16'sd27246,  16'sd12540,  16'sd6393,
      -16'sd23170, 16'sd32138, -16'sd30274,  16'sd18205,
      16'sd23170, -16'sd32138,  16'sd30274, -16'sd27246,
      16'sd23170, -16'sd18205,  16'sd12540, -16'sd6393
   };

   logic signed [CosWidth-1:0] entry;

   // row-major lookup
   assign entry = CosTable[{row, col}];
   assign coef  = {{(OperandWidth - CosWidth){entry[CosWidth-1]}}, entry};

endmodule

// File: hw/blockBuffer.sv
// 8x8 word buffer, one write port and one asynchronous read port
`timescale 1ns/10ps

module blockBuffer #(
   parameter int DataWidth = 32
) (
   input  logic                           clk,
   input  logic                           racc,
   input  logic                           writeEnable,
   input  logic [idctPkg::IndexWidth-1:0] writeRow,
   input  logic [idctPkg::IndexWidth-1:0] writeCol,
   input  logic [DataWidth-1:0]           writeData,
   input  logic [idctPkg::IndexWidth-1:0] readRow,
   input  logic [idctPkg::IndexWidth-1:0] readCol,
   output logic [DataWidth-1:0]           readData
);
   import idctPkg::*;

   logic [DataWidth-1:0] mem [BlockDim][BlockDim];

   always_ff @(posedge clk or posedge racc)
   begin
      if (racc)
      begin
         for (int r = 0; r < BlockDim; r++)
         begin
            for (int c = 0; c < BlockDim; c++)
            begin
               mem[r][c] <= '0;
            end
         end
      end
      else if (writeEnable)
      begin
         mem[writeRow][writeCol] <= writeData;
      end
   end

   assign readData = mem[readRow][readCol];

   // sequencer must keep every write port quiet during reset
   assert property (@(posedge clk) racc |-> !writeEnable)
      else $error("write into block buffer while reset is active");

endmodule

// File: hw/macUnit.sv
// shared multiply-accumulate datapath
// operand register, truncated product register, guarded accumulator
`timescale 1ns/10ps

module macUnit #(
   parameter int DataWidth    = 32,
   parameter int OperandWidth = 24
) (
   input  logic                                   clk,
   input  logic                                   racc,
   input  logic [OperandWidth-1:0]                operandA,
   input  logic [OperandWidth-1:0]                operandB,
   input  logic                                   macEnable,
   input  logic                                   macClear,
   output logic [DataWidth+idctPkg::AccGuard-1:0] accum
);
   import idctPkg::*;

   logic [OperandWidth-1:0]       opA;
   logic [OperandWidth-1:0]       opB;
   logic [2*OperandWidth-1:0]     fullProduct;
   logic [DataWidth-1:0]          product;
   logic [DataWidth+AccGuard-1:0] productExt;
   logic                          enStage1;
   logic                          clrStage1;
   logic                          enStage2;
   logic                          clrStage2;

   assign fullProduct = $signed(opA) * $signed(opB);
   assign productExt  = {{AccGuard{product[DataWidth-1]}}, product};

   // datapath stages
   always_ff @(posedge clk)
   begin
      opA     <= operandA;
      opB     <= operandB;
      product <= fullProduct[DataWidth-1:0];
   end

   // enable and clear follow their operands down the pipe
   always_ff @(posedge clk or posedge racc)
   begin
      if (racc)
      begin
         enStage1  <= 1'b0;
         clrStage1 <= 1'b0;
         enStage2  <= 1'b0;
         clrStage2 <= 1'b0;
         accum     <= '0;
      end
      else
      begin
         enStage1  <= macEnable;
         clrStage1 <= macClear;
         enStage2  <= enStage1;
         clrStage2 <= clrStage1;
         if (enStage2)
         begin
            // first term of a sum replaces the previous total
            accum <= clrStage2 ? productExt : accum + productExt;
         end
      end
   end

   assert property (@(posedge clk) disable iff (racc) macClear |-> macEnable)
      else $error("accumulator clear requested outside an enabled step");

endmodule

// File: hw/idctSequencer.sv
// IDCT sequencer FSM and step counter
// operand addressing, MAC control and write-back index delay line
`timescale 1ns/10ps

module idctSequencer (
   input  logic                           clk,
   input  logic                           racc,
   input  logic                           start,
   output logic                           reading,
   output logic                           done,
   output logic                           outValid,
   output logic                           passSelect,
   output logic [idctPkg::IndexWidth-1:0] readRow,
   output logic [idctPkg::IndexWidth-1:0] readCol,
   output logic [idctPkg::IndexWidth-1:0] cosRow,
   output logic [idctPkg::IndexWidth-1:0] cosCol,
   output logic                           macEnable,
   output logic                           macClear,
   output logic                           inWrite,
   output logic                           tempWrite,
   output logic                           outWrite,
   output logic [idctPkg::IndexWidth-1:0] writeRow,
   output logic [idctPkg::IndexWidth-1:0] writeCol
);
   import idctPkg::*;

   // operand and product registers ahead of the accumulator
   localparam int MacLatency  = 2;
   localparam int FlushCycles = MacLatency + 1;
   localparam int PassSteps   = BlockWords * BlockDim;

   idctState              state;
   logic [StepWidth-1:0]  count;
   logic [IndexWidth-1:0] idxI;
   logic [IndexWidth-1:0] idxJ;
   logic [IndexWidth-1:0] idxK;
   logic                  colPass;
   logic                  lastTerm;
   logic [MacLatency-1:0] lastDly;
   logic [MacLatency-1:0] passDly;
   logic [IndexWidth-1:0] iDly [MacLatency];
   logic [IndexWidth-1:0] jDly [MacLatency];
   logic [IndexWidth-1:0] wbRow;
   logic [IndexWidth-1:0] wbCol;

   // step count is {i, j, k}, k runs fastest
   assign idxI = count[StepWidth-1 -: IndexWidth];
   assign idxJ = count[2*IndexWidth-1 -: IndexWidth];
   assign idxK = count[IndexWidth-1:0];

   assign colPass    = (state == ColPass);
   assign passSelect = colPass;
   assign macEnable  = (state == RowPass) || colPass;
   assign macClear   = macEnable && (idxK == '0);
   assign lastTerm   = macEnable && (idxK == IndexWidth'(BlockDim - 1));
   assign inWrite    = (state == Load);

   // row pass reads In[j][k] with cos[i][k], column pass Temp[k][i] with cos[j][k]
   assign readRow = colPass ? idxK : idxJ;
   assign readCol = colPass ? idxI : idxK;
   assign cosRow  = colPass ? idxJ : idxI;
   assign cosCol  = idxK;

   assign writeRow = inWrite ? idxJ : wbRow;
   assign writeCol = inWrite ? idxK : wbCol;

   always_ff @(posedge clk or posedge racc)
   begin
      if (racc)
      begin
         state    <= Idle;
         count    <= '0;
         reading  <= 1'b0;
         done     <= 1'b0;
         outValid <= 1'b0;
      end
      else
      begin
         done     <= 1'b0;
         outValid <= (state == Unload);
         case (state)
            Idle:
            begin
               count <= '0;
               if (start)
               begin
                  state   <= Load;
                  reading <= 1'b1;
               end
            end
            Load:
            begin
               count <= count + 1'b1;
               if (count == StepWidth'(BlockWords - 1))
               begin
                  state   <= RowPass;
                  reading <= 1'b0;
                  count   <= '0;
               end
            end
            RowPass, ColPass:
            begin
               count <= count + 1'b1;
               if (count == StepWidth'(PassSteps - 1))
               begin
                  state <= colPass ? ColFlush : RowFlush;
                  count <= '0;
               end
            end
            RowFlush, ColFlush:
            begin
               count <= count + 1'b1;
               // last sums drain out of the MAC
               if (count == StepWidth'(FlushCycles - 1))
               begin
                  state <= (state == ColFlush) ? Unload : ColPass;
                  done  <= (state == ColFlush);
                  count <= '0;
               end
            end
            Unload:
            begin
               count <= count + 1'b1;
               if (count == StepWidth'(BlockWords - 1))
               begin
                  state <= Idle;
                  count <= '0;
               end
            end
            default:
            begin
               state <= Idle;
            end
         endcase
      end
   end

   // write strobes trail the last term by the MAC latency plus one
   always_ff @(posedge clk or posedge racc)
   begin
      if (racc)
      begin
         lastDly   <= '0;
         passDly   <= '0;
         tempWrite <= 1'b0;
         outWrite  <= 1'b0;
      end
      else
      begin
         lastDly   <= {lastDly[MacLatency-2:0], lastTerm};
         passDly   <= {passDly[MacLatency-2:0], colPass};
         tempWrite <= lastDly[MacLatency-1] && !passDly[MacLatency-1];
         outWrite  <= lastDly[MacLatency-1] && passDly[MacLatency-1];
      end
   end

   // both passes store the sum at row j, column i
   always_ff @(posedge clk)
   begin
      iDly[0] <= idxI;
      jDly[0] <= idxJ;
      for (int s = 1; s < MacLatency; s++)
      begin
         iDly[s] <= iDly[s-1];
         jDly[s] <= jDly[s-1];
      end
      wbRow <= jDly[MacLatency-1];
      wbCol <= iDly[MacLatency-1];
   end

   assert property (@(posedge clk) disable iff (racc) !(reading && outValid))
      else $error("input load overlaps result unload");

endmodule

// File: hw/idctTop.sv
// 8x8 inverse DCT top level
// sequencer, cosine ROM, three block buffers and the shared MAC
`timescale 1ns/10ps

module idctTop #(
   parameter int DataWidth    = 32,
   parameter int OperandWidth = 24
) (
   input  logic                 clk,
   input  logic                 racc,
   input  logic                 start,
   input  logic [DataWidth-1:0] din,
   output logic                 reading,
   output logic                 done,
   output logic [DataWidth-1:0] dout,
   output logic                 outValid
);
   import idctPkg::*;

   logic                          passSelect;
   logic [IndexWidth-1:0]         readRow;
   logic [IndexWidth-1:0]         readCol;
   logic [IndexWidth-1:0]         cosRow;
   logic [IndexWidth-1:0]         cosCol;
   logic                          macEnable;
   logic                          macClear;
   logic                          inWrite;
   logic                          tempWrite;
   logic                          outWrite;
   logic [IndexWidth-1:0]         writeRow;
   logic [IndexWidth-1:0]         writeCol;
   logic [DataWidth-1:0]          inData;
   logic [DataWidth-1:0]          tempData;
   logic [DataWidth-1:0]          outData;
   logic [OperandWidth-1:0]       coef;
   logic [OperandWidth-1:0]       operandA;
   logic [DataWidth+AccGuard-1:0] accum;

   idctSequencer seq_i (
      .clk(clk), .racc(racc), .start(start),
      .reading(reading), .done(done), .outValid(outValid),
      .passSelect(passSelect),
      .readRow(readRow), .readCol(readCol), .cosRow(cosRow), .cosCol(cosCol),
      .macEnable(macEnable), .macClear(macClear),
      .inWrite(inWrite), .tempWrite(tempWrite), .outWrite(outWrite),
      .writeRow(writeRow), .writeCol(writeCol)
   );

   cosineRom #(.OperandWidth(OperandWidth)) rom_i (
      .row(cosRow), .col(cosCol), .coef(coef)
   );

   blockBuffer #(.DataWidth(DataWidth)) inBuf (
      .clk(clk), .racc(racc), .writeEnable(inWrite),
      .writeRow(writeRow), .writeCol(writeCol), .writeData(din),
      .readRow(readRow), .readCol(readCol), .readData(inData)
   );

   // row sums kept at full data width
   blockBuffer #(.DataWidth(DataWidth)) tempBuf (
      .clk(clk), .racc(racc), .writeEnable(tempWrite),
      .writeRow(writeRow), .writeCol(writeCol), .writeData(accum[DataWidth-1:0]),
      .readRow(readRow), .readCol(readCol), .readData(tempData)
   );

   // column sums drop the guard-bit scaling
   blockBuffer #(.DataWidth(DataWidth)) outBuf (
      .clk(clk), .racc(racc), .writeEnable(outWrite),
      .writeRow(writeRow), .writeCol(writeCol),
      .writeData(accum[DataWidth+AccGuard-1 -: DataWidth]),
      .readRow(readRow), .readCol(readCol), .readData(outData)
   );

   // column pass takes the upper bits of the row results
   assign operandA = passSelect ? tempData[DataWidth-1 -: OperandWidth]
                                : inData[OperandWidth-1:0];

   macUnit #(.DataWidth(DataWidth), .OperandWidth(OperandWidth)) mac_i (
      .clk(clk), .racc(racc),
      .operandA(operandA), .operandB(coef),
      .macEnable(macEnable), .macClear(macClear),
      .accum(accum)
   );

   always_ff @(posedge clk or posedge racc)
   begin
      if (racc)
      begin
         dout <= '0;
      end
      else
      begin
         dout <= outData;
      end
   end

endmodule

// File: testbench/idctTb.sv
// testbench for the 8x8 IDCT top level
// trace-driven stimulus, output checks, watchdog and summary
`timescale 1ns/10ps

module idctTb;

   localparam int DataWidth       = 32;
   localparam int OperandWidth    = 24;
   localparam int BlockWords      = 64;
   localparam int PassCycles      = 512 + 3;
   // load, both passes with flush, done and unload
   localparam int BlockCycles     = 2 * BlockWords + 2 * PassCycles + 1;
   localparam int WatchdogCycles  = 3 * BlockCycles + 600;
   localparam int StrayStartCycle = 300;

   logic                 clk;
   logic                 racc;
   logic                 start;
   logic [DataWidth-1:0] din;
   logic                 reading;
   logic                 done;
   logic [DataWidth-1:0] dout;
   logic                 outValid;

   // even entries are input samples, odd entries expected results
   logic [DataWidth-1:0] traceMem [2*BlockWords];
   integer               seed;
   int                   errorCount;
   int                   checkCount;
   bit                   firstRun;

   idctTop #(.DataWidth(DataWidth), .OperandWidth(OperandWidth)) dut_i (
      .clk(clk), .racc(racc), .start(start), .din(din),
      .reading(reading), .done(done), .dout(dout), .outValid(outValid)
   );

   always
   begin
      #5 clk = ~clk;
   end

   task automatic reportError(input string msg);
      errorCount++;
      $display("[ERROR] %0t: %s", $time, msg);
   endtask

   // handshake outputs stay quiet between blocks
   task automatic checkIdle();
      checkCount++;
      if (reading !== 1'b0 || done !== 1'b0 || outValid !== 1'b0)
      begin
         reportError($sformatf("handshake active while idle: reading=%b done=%b outValid=%b",
                               reading, done, outValid));
      end
      if (firstRun && dout !== '0)
      begin
         reportError($sformatf("dout = %h before the first block, expected zero", dout));
      end
   endtask

   task automatic runBlock(input bit zeroBlock, input bit pokeStart);
      int                   gap;
      int                   loadCount;
      int                   cycle;
      logic [DataWidth-1:0] expected;
      gap = 2 + ($unsigned($random(seed)) % 16);
      repeat (gap)
      begin
         @(negedge clk);
         checkIdle();
      end
      start = 1'b1;
      @(negedge clk);
      start = 1'b0;
      firstRun = 1'b0;
      // feed one sample per cycle while the DUT is loading
      loadCount = 0;
      while (reading === 1'b1)
      begin
         din = zeroBlock ? '0 : traceMem[2 * (loadCount % BlockWords)];
         loadCount++;
         @(negedge clk);
      end
      din = '0;
      checkCount++;
      if (loadCount != BlockWords)
      begin
         reportError($sformatf("reading high for %0d cycles, expected %0d",
                               loadCount, BlockWords));
      end
      // compute phase, optionally with a stray start pulse
      cycle = 0;
      while (done !== 1'b1)
      begin
         if (reading !== 1'b0 || outValid !== 1'b0)
         begin
            reportError("reading or outValid active during the compute passes");
         end
         start = pokeStart && (cycle == StrayStartCycle);
         @(negedge clk);
         cycle++;
      end
      start = 1'b0;
      for (int n = 0; n < BlockWords; n++)
      begin
         @(negedge clk);
         expected = zeroBlock ? '0 : traceMem[2 * n + 1];
         checkCount++;
         if (outValid !== 1'b1 || done !== 1'b0)
         begin
            reportError($sformatf("outValid=%b done=%b at unload word %0d",
                                  outValid, done, n));
         end
         if (dout !== expected)
         begin
            reportError($sformatf("dout[%0d] = %h, expected %h", n, dout, expected));
         end
      end
      @(negedge clk);
      checkCount++;
      if (outValid !== 1'b0 || done !== 1'b0)
      begin
         reportError("outValid or done still high after the 64th word");
      end
   endtask

   initial
   begin
      repeat (WatchdogCycles) @(posedge clk);
      $display("watchdog expired after %0d cycles, the DUT stopped making progress",
               WatchdogCycles);
      $display("SIMULATION FAILED");
      $finish;
   end

   initial
   begin
      clk        = 1'b0;
      racc       = 1'b1;
      start      = 1'b0;
      din        = '0;
      seed       = 32'haeb4;
      errorCount = 0;
      checkCount = 0;
      firstRun   = 1'b1;
      $readmemh("testbench/idctTrace.txt", traceMem);
      repeat (10) @(negedge clk);
      racc = 1'b0;
      // trace block, stray start during the passes
      runBlock(1'b0, 1'b1);
      // same block again after a fresh gap
      runBlock(1'b0, 1'b0);
      runBlock(1'b1, 1'b0);
      // no late done or restart
      repeat (20)
      begin
         @(negedge clk);
         checkIdle();
      end
      $display("idct testbench summary: %0d checks, %0d errors", checkCount, errorCount);
      if (errorCount == 0)
      begin
         $display("SIMULATION PASSED");
      end
      else
      begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

// File: testbench/idctTrace.txt
// columns: input sample, expected output (hex, 32 bit)
// one line per block position, row-major (row j, column k)
00000100 0D8C3303
00000100 0CB4017C
00000000 0B247458
00000000 091A718F
00000000 06E56372
00000000 04DB60A9
00000000 034BD385
00000000 0273A1FE
00000000 058C4882
00000000 04B416FB
00000000 032489D7
00000000 011A870E
00000000 FEE578F1
00000000 FCDB7628
00000000 FB4BE904
00000000 FA73B77D
00000000 058C4882
00000000 04B416FB
00000000 032489D7
00000000 011A870E
00000000 FEE578F1
00000000 FCDB7628
00000000 FB4BE904
00000000 FA73B77D
00000000 0D8C3303
00000000 0CB4017C
00000000 0B247458
00000000 091A718F
00000000 06E56372
00000000 04DB60A9
00000000 034BD385
00000000 0273A1FE
00000100 0D8C3303
00000000 0CB4017C
00000000 0B247458
00000000 091A718F
00000000 06E56372
00000000 04DB60A9
00000000 034BD385
00000000 0273A1FE
00000000 058C4882
00000000 04B416FB
00000000 032489D7
00000000 011A870E
00000000 FEE578F1
00000000 FCDB7628
00000000 FB4BE904
00000000 FA73B77D
00000000 058C4882
00000000 04B416FB
00000000 032489D7
00000000 011A870E
00000000 FEE578F1
00000000 FCDB7628
00000000 FB4BE904
00000000 FA73B77D
00000000 0D8C3303
00000000 0CB4017C
00000000 0B247458
00000000 091A718F
00000000 06E56372
00000000 04DB60A9
00000000 034BD385
00000000 0273A1FE

// File: idctTop.f
hw/idctPkg.sv
hw/cosineRom.sv
hw/blockBuffer.sv
hw/macUnit.sv
hw/idctSequencer.sv
hw/idctTop.sv
testbench/idctTb.sv

// File: run.sh
#!/bin/sh
# build the IDCT testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module idctTb \
   -f idctTop.f -o simIdct || { echo "verilator build failed"; exit 1; }
./obj_dir/simIdct > sim.log 2>&1 || echo "simulator returned a nonzero status"
cat sim.log
grep -q "SIMULATION FAILED" sim.log && { echo "run failed"; exit 1; }
grep -q "SIMULATION PASSED" sim.log || { echo "no result found in sim.log"; exit 1; }
echo "run passed"
exit 0
